// ==== rename_core.f ====
common/rename_pkg.sv
source/inst_buffer.sv
rename/free_list.sv
rename/rename_stage.sv
source/execute_stage.sv
source/commit_stage.sv
source/rename_core.sv
testbench/rename_core_assertions.sv
testbench/rename_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rename_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f rename_core.f --top-module rename_core_tb \
  -o rename_core_sim || { echo "Build failed"; exit 1; }
out=$(./obj_dir/rename_core_sim)
echo "$out"
echo "$out" | grep -q "^Test completed successfully$" && exit 0 || exit 1

// ==== testbench/rename_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rename_core_tb;

  import rename_pkg::*;

  localparam int table_len      = 40;
  localparam int timeout_cycles = 20 * table_len + 200;

  logic      clock = 1'b0;
  logic      rst_n;
  logic      in_valid;
  op_t       in_op;
  arch_reg_t in_dest;
  arch_reg_t in_src1;
  arch_reg_t in_src2;
  imm_t      in_imm;
  logic      commit_ready;
  logic      in_ready;
  logic      commit_valid;
  arch_reg_t commit_idx;
  word_t     commit_data;
  phys_reg_t commit_tag;

  // Stimulus table
  op_t       t_op   [table_len];
  arch_reg_t t_dest [table_len];
  arch_reg_t t_src1 [table_len];
  arch_reg_t t_src2 [table_len];
  imm_t      t_imm  [table_len];
  int        n_loaded = 0;

  // Reference model state
  word_t     arf       [num_arch_regs];
  phys_reg_t map_model [num_arch_regs];
  phys_reg_t free_q    [$];

  int n_commits    = 0;
  int idx_errors   = 0;
  int data_errors  = 0;
  int tag_errors   = 0;
  int other_errors = 0;
  int cycles       = 0;

  rename_core dut0 (
    .clock        (clock),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .in_op        (in_op),
    .in_dest      (in_dest),
    .in_src1      (in_src1),
    .in_src2      (in_src2),
    .in_imm       (in_imm),
    .commit_ready (commit_ready),
    .in_ready     (in_ready),
    .commit_valid (commit_valid),
    .commit_idx   (commit_idx),
    .commit_data  (commit_data),
    .commit_tag   (commit_tag)
  );

  always #10 clock = ~clock;

  task automatic add_inst(input op_t op, input int dest, input int src1, input int src2,
                          input int imm);
    t_op[n_loaded]   = op;
    t_dest[n_loaded] = arch_reg_t'(dest);
    t_src1[n_loaded] = arch_reg_t'(src1);
    t_src2[n_loaded] = arch_reg_t'(src2);
    t_imm[n_loaded]  = imm_t'(imm);
    n_loaded++;
  endtask

  task automatic load_table();
    add_inst(op_li,   1,  0,  0,  'h0005);
    add_inst(op_li,   2,  0,  0,  'h0007);
    add_inst(op_li,   3,  0,  0,  'hffff);
    add_inst(op_li,   4,  0,  0,  'h1234);
    add_inst(op_add,  5,  1,  2,  0);
    add_inst(op_sub,  6,  1,  2,  0);  // Wraps below zero
    add_inst(op_xor,  7,  3,  4,  0);
    add_inst(op_add,  8,  10, 11, 0);  // Never written sources
    add_inst(op_sub,  9,  12, 1,  0);
    add_inst(op_xor,  10, 20, 3,  0);
    add_inst(op_add,  1,  1,  1,  0);
    add_inst(op_add,  1,  1,  1,  0);
    add_inst(op_add,  1,  1,  5,  0);
    add_inst(op_sub,  2,  2,  1,  0);
    add_inst(op_xor,  2,  2,  3,  0);
    add_inst(op_li,   5,  0,  0,  'h8000);
    add_inst(op_add,  5,  5,  5,  0);  // Freed tags reused from here on
    add_inst(op_add,  5,  5,  5,  0);
    add_inst(op_sub,  6,  6,  6,  0);
    add_inst(op_li,   31, 0,  0,  'habcd);
    add_inst(op_add,  30, 31, 31, 0);
    add_inst(op_xor,  29, 30, 31, 0);
    add_inst(op_sub,  28, 0,  29, 0);
    add_inst(op_li,   0,  0,  0,  'h0001);
    add_inst(op_add,  0,  0,  0,  0);
    add_inst(op_add,  0,  0,  0,  0);
    add_inst(op_add,  0,  0,  0,  0);
    add_inst(op_sub,  27, 0,  2,  0);
    add_inst(op_xor,  26, 27, 28, 0);
    add_inst(op_li,   3,  0,  0,  'h00ff);
    add_inst(op_add,  4,  3,  4,  0);
    add_inst(op_sub,  4,  4,  3,  0);
    add_inst(op_xor,  4,  4,  4,  0);
    add_inst(op_add,  25, 4,  24, 0);
    add_inst(op_li,   24, 0,  0,  'h7fff);
    add_inst(op_add,  24, 24, 24, 0);
    add_inst(op_sub,  23, 24, 1,  0);
    add_inst(op_xor,  22, 23, 2,  0);
    add_inst(op_add,  21, 22, 5,  0);
    add_inst(op_sub,  20, 21, 21, 0);
  endtask

  task automatic check_idx(input arch_reg_t got, input arch_reg_t exp, input int n);
    if (got !== exp) begin
      idx_errors++;
      $display("error %0t: commit %0d index %0d, expected %0d", $time, n, got, exp);
    end
  endtask

  task automatic check_data(input word_t got, input word_t exp, input int n);
    if (got !== exp) begin
      data_errors++;
      $display("error %0t: commit %0d data %h, expected %h", $time, n, got, exp);
    end
  endtask

  task automatic check_tag(input phys_reg_t got, input phys_reg_t exp, input int n);
    if (got !== exp) begin
      tag_errors++;
      $display("error %0t: commit %0d tag %0d, expected %0d", $time, n, got, exp);
    end
  endtask

  // Model steps one instruction in program order per commit
  task automatic check_commit();
    word_t     a;
    word_t     b;
    word_t     res;
    phys_reg_t new_tag;
    phys_reg_t old_tag;
    arch_reg_t d;
    int        n;
    n = n_commits;
    if (n >= table_len) begin
      other_errors++;
      $display("Unexpected commit at %0t after all %0d instructions committed", $time, n);
    end else begin
      d = t_dest[n];
      a = arf[t_src1[n]];
      b = arf[t_src2[n]];
      case (t_op[n])
        op_li:   res = {16'h0000, t_imm[n]};
        op_add:  res = a + b;
        op_sub:  res = a - b;
        default: res = a ^ b;
      endcase
      new_tag = free_q.pop_front();
      old_tag = map_model[d];
      map_model[d] = new_tag;
      arf[d] = res;
      check_idx(commit_idx, d, n);
      check_data(commit_data, res, n);
      check_tag(commit_tag, new_tag, n);
      free_q.push_back(old_tag);  // Old mapping freed at commit
      n_commits++;
    end
  endtask

  task automatic report_counts();
    $display("Errors: index %0d, data %0d, tag %0d, other %0d, assertions %0d",
             idx_errors, data_errors, tag_errors, other_errors,
             dut0.asrt0.assert_failures);
  endtask

  // Commit handshake sampled midway between edges
  always @(negedge clock) begin
    if (rst_n && commit_valid && commit_ready) check_commit();
  end

  always @(posedge clock) begin
    if (rst_n) begin
      #2;
      commit_ready = ($urandom % 4) != 0;  // Drop roughly one cycle in four
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("Timeout after %0d cycles with %0d of %0d instructions committed",
               cycles, n_commits, table_len);
      report_counts();
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    int idle;
    int total;
    void'($urandom(32'h6b6d));
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_op        = op_li;
    in_dest      = '0;
    in_src1      = '0;
    in_src2      = '0;
    in_imm       = '0;
    commit_ready = 1'b1;
    for (int i = 0; i < num_arch_regs; i++) begin
      arf[i]       = '0;
      map_model[i] = phys_reg_t'(i);
    end
    for (int i = 0; i < num_free; i++) begin
      free_q.push_back(phys_reg_t'(num_arch_regs + i));
    end
    load_table();

    repeat (16) @(posedge clock);
    #2;
    rst_n = 1'b1;

    for (int i = 0; i < table_len; i++) begin
      idle = ($urandom % 4 == 0) ? int'($urandom % 3) + 1 : 0;
      repeat (idle) begin
        @(posedge clock);
        #2;
      end
      in_valid = 1'b1;
      in_op    = t_op[i];
      in_dest  = t_dest[i];
      in_src1  = t_src1[i];
      in_src2  = t_src2[i];
      in_imm   = t_imm[i];
      @(negedge clock);
      while (!in_ready) @(negedge clock);
      @(posedge clock);
      #2;
      in_valid = 1'b0;
    end

    while (n_commits < table_len) @(posedge clock);
    repeat (20) @(posedge clock);  // Catch any extra commit

    total = idx_errors + data_errors + tag_errors + other_errors
          + int'(dut0.asrt0.assert_failures);
    report_counts();
    if (total == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/rename_core_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module rename_core_assertions (
  input logic                  clock,
  input logic                  rst_n,
  input logic                  in_valid,
  input logic                  in_ready,
  input rename_pkg::op_t       in_op,
  input rename_pkg::arch_reg_t in_dest,
  input rename_pkg::arch_reg_t in_src1,
  input rename_pkg::arch_reg_t in_src2,
  input rename_pkg::imm_t      in_imm,
  input logic                  commit_valid,
  input logic                  commit_ready,
  input rename_pkg::arch_reg_t commit_idx,
  input rename_pkg::word_t     commit_data,
  input rename_pkg::phys_reg_t commit_tag
);

  int unsigned assert_failures = 0;

  // Stalled commit holds its data
  commit_hold: assert property (@(posedge clock) disable iff (!rst_n)
    commit_valid && !commit_ready |=> commit_valid && $stable(commit_idx)
      && $stable(commit_data) && $stable(commit_tag))
  else begin
    assert_failures++;
    $error("commit port changed while commit_ready was low");
  end

  reset_idle: assert property (@(posedge clock) !rst_n |-> !commit_valid)
  else begin
    assert_failures++;
    $error("commit_valid high during reset");
  end

  input_hold: assert property (@(posedge clock) disable iff (!rst_n)
    in_valid && !in_ready |=> in_valid && $stable(in_op) && $stable(in_dest)
      && $stable(in_src1) && $stable(in_src2) && $stable(in_imm))
  else begin
    assert_failures++;
    $error("input changed while in_ready was low");
  end

endmodule

bind rename_core rename_core_assertions asrt0 (.*);

`default_nettype wire

// ==== source/rename_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module rename_core (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  rename_pkg::op_t       in_op,
  input  rename_pkg::arch_reg_t in_dest,
  input  rename_pkg::arch_reg_t in_src1,
  input  rename_pkg::arch_reg_t in_src2,
  input  rename_pkg::imm_t      in_imm,
  input  logic                  commit_ready,
  output logic                  in_ready,
  output logic                  commit_valid,
  output rename_pkg::arch_reg_t commit_idx,
  output rename_pkg::word_t     commit_data,
  output rename_pkg::phys_reg_t commit_tag
);

  import rename_pkg::*;

  // Buffer to rename
  logic      buf_valid;
  logic      buf_ready;
  op_t       buf_op;
  arch_reg_t buf_dest;
  arch_reg_t buf_src1;
  arch_reg_t buf_src2;
  imm_t      buf_imm;

  // Rename to execute
  logic      ren_valid;
  logic      ren_ready;
  op_t       ren_op;
  imm_t      ren_imm;
  arch_reg_t ren_dest;
  phys_reg_t ren_tag;
  phys_reg_t ren_old_tag;
  phys_reg_t ren_src1_tag;
  phys_reg_t ren_src2_tag;

  // Execute to commit
  logic      ex_valid;
  logic      ex_ready;
  arch_reg_t ex_dest;
  phys_reg_t ex_tag;
  phys_reg_t ex_old_tag;
  word_t     ex_result;

  logic      reclaim_valid;
  phys_reg_t reclaim_tag;

  inst_buffer buf0 (
    .clock     (clock),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_op     (in_op),
    .in_dest   (in_dest),
    .in_src1   (in_src1),
    .in_src2   (in_src2),
    .in_imm    (in_imm),
    .buf_ready (buf_ready),
    .in_ready  (in_ready),
    .buf_valid (buf_valid),
    .buf_op    (buf_op),
    .buf_dest  (buf_dest),
    .buf_src1  (buf_src1),
    .buf_src2  (buf_src2),
    .buf_imm   (buf_imm)
  );

  rename_stage ren0 (
    .clock         (clock),
    .rst_n         (rst_n),
    .buf_valid     (buf_valid),
    .buf_op        (buf_op),
    .buf_dest      (buf_dest),
    .buf_src1      (buf_src1),
    .buf_src2      (buf_src2),
    .buf_imm       (buf_imm),
    .ren_ready     (ren_ready),
    .reclaim_valid (reclaim_valid),
    .reclaim_tag   (reclaim_tag),
    .buf_ready     (buf_ready),
    .ren_valid     (ren_valid),
    .ren_op        (ren_op),
    .ren_imm       (ren_imm),
    .ren_dest      (ren_dest),
    .ren_tag       (ren_tag),
    .ren_old_tag   (ren_old_tag),
    .ren_src1_tag  (ren_src1_tag),
    .ren_src2_tag  (ren_src2_tag)
  );

  execute_stage ex0 (
    .clock        (clock),
    .rst_n        (rst_n),
    .ren_valid    (ren_valid),
    .ren_op       (ren_op),
    .ren_imm      (ren_imm),
    .ren_dest     (ren_dest),
    .ren_tag      (ren_tag),
    .ren_old_tag  (ren_old_tag),
    .ren_src1_tag (ren_src1_tag),
    .ren_src2_tag (ren_src2_tag),
    .ex_ready     (ex_ready),
    .ren_ready    (ren_ready),
    .ex_valid     (ex_valid),
    .ex_dest      (ex_dest),
    .ex_tag       (ex_tag),
    .ex_old_tag   (ex_old_tag),
    .ex_result    (ex_result)
  );

  commit_stage com0 (
    .clock         (clock),
    .rst_n         (rst_n),
    .ex_valid      (ex_valid),
    .ex_dest       (ex_dest),
    .ex_tag        (ex_tag),
    .ex_old_tag    (ex_old_tag),
    .ex_result     (ex_result),
    .commit_ready  (commit_ready),
    .ex_ready      (ex_ready),
    .commit_valid  (commit_valid),
    .commit_idx    (commit_idx),
    .commit_data   (commit_data),
    .commit_tag    (commit_tag),
    .reclaim_valid (reclaim_valid),
    .reclaim_tag   (reclaim_tag)
  );

endmodule

`default_nettype wire

// ==== source/commit_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module commit_stage (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  ex_valid,
  input  rename_pkg::arch_reg_t ex_dest,
  input  rename_pkg::phys_reg_t ex_tag,
  input  rename_pkg::phys_reg_t ex_old_tag,
  input  rename_pkg::word_t     ex_result,
  input  logic                  commit_ready,
  output logic                  ex_ready,
  output logic                  commit_valid,
  output rename_pkg::arch_reg_t commit_idx,
  output rename_pkg::word_t     commit_data,
  output rename_pkg::phys_reg_t commit_tag,
  output logic                  reclaim_valid,
  output rename_pkg::phys_reg_t reclaim_tag
);

  import rename_pkg::*;

  phys_reg_t old_tag_q;  // Displaced mapping, freed at commit
  logic      take;

  assign ex_ready = !commit_valid || commit_ready;
  assign take     = ex_valid && ex_ready;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      commit_valid <= 1'b0;
    end else if (take) begin
      commit_valid <= 1'b1;
    end else if (commit_ready) begin
      commit_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      commit_idx  <= ex_dest;
      commit_data <= ex_result;
      commit_tag  <= ex_tag;
      old_tag_q   <= ex_old_tag;
    end
  end

  // One push per commit handshake
  assign reclaim_valid = commit_valid && commit_ready;
  assign reclaim_tag   = old_tag_q;

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  ren_valid,
  input  rename_pkg::op_t       ren_op,
  input  rename_pkg::imm_t      ren_imm,
  input  rename_pkg::arch_reg_t ren_dest,
  input  rename_pkg::phys_reg_t ren_tag,
  input  rename_pkg::phys_reg_t ren_old_tag,
  input  rename_pkg::phys_reg_t ren_src1_tag,
  input  rename_pkg::phys_reg_t ren_src2_tag,
  input  logic                  ex_ready,
  output logic                  ren_ready,
  output logic                  ex_valid,
  output rename_pkg::arch_reg_t ex_dest,
  output rename_pkg::phys_reg_t ex_tag,
  output rename_pkg::phys_reg_t ex_old_tag,
  output rename_pkg::word_t     ex_result
);

  import rename_pkg::*;

  word_t prf [num_phys_regs];
  word_t src1_val;
  word_t src2_val;
  word_t result;
  logic  take;

  assign ren_ready = !ex_valid || ex_ready;
  assign take      = ren_valid && ren_ready;

  always_comb begin
    src1_val = prf[ren_src1_tag];
    src2_val = prf[ren_src2_tag];
    case (ren_op)
      op_li:   result = word_t'(ren_imm);
      op_add:  result = src1_val + src2_val;
      op_sub:  result = src1_val - src2_val;  // Wraps modulo 2**32
      default: result = src1_val ^ src2_val;
    endcase
  end

  // Unwritten registers read as zero
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_phys_regs; i++) begin
        prf[i] <= '0;
      end
      ex_valid <= 1'b0;
    end else begin
      if (take) prf[ren_tag] <= result;  // Visible to the next instruction
      if (take) ex_valid <= 1'b1;
      else if (ex_ready) ex_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      ex_dest    <= ren_dest;
      ex_tag     <= ren_tag;
      ex_old_tag <= ren_old_tag;
      ex_result  <= result;
    end
  end

endmodule

`default_nettype wire

// ==== rename/rename_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module rename_stage (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  buf_valid,
  input  rename_pkg::op_t       buf_op,
  input  rename_pkg::arch_reg_t buf_dest,
  input  rename_pkg::arch_reg_t buf_src1,
  input  rename_pkg::arch_reg_t buf_src2,
  input  rename_pkg::imm_t      buf_imm,
  input  logic                  ren_ready,
  input  logic                  reclaim_valid,
  input  rename_pkg::phys_reg_t reclaim_tag,
  output logic                  buf_ready,
  output logic                  ren_valid,
  output rename_pkg::op_t       ren_op,
  output rename_pkg::imm_t      ren_imm,
  output rename_pkg::arch_reg_t ren_dest,
  output rename_pkg::phys_reg_t ren_tag,
  output rename_pkg::phys_reg_t ren_old_tag,
  output rename_pkg::phys_reg_t ren_src1_tag,
  output rename_pkg::phys_reg_t ren_src2_tag
);

  import rename_pkg::*;

  phys_reg_t map_table [num_arch_regs];
  logic      free_valid;
  phys_reg_t free_tag;
  logic      take;

  free_list fl0 (
    .clock         (clock),
    .rst_n         (rst_n),
    .alloc         (take),
    .reclaim_valid (reclaim_valid),
    .reclaim_tag   (reclaim_tag),
    .free_valid    (free_valid),
    .free_tag      (free_tag)
  );

  // Stall while no tag is free
  assign buf_ready = free_valid && (!ren_valid || ren_ready);
  assign take      = buf_valid && buf_ready;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_arch_regs; i++) begin
        map_table[i] <= phys_reg_t'(i);
      end
      ren_valid <= 1'b0;
    end else begin
      if (take) map_table[buf_dest] <= free_tag;
      if (take) ren_valid <= 1'b1;
      else if (ren_ready) ren_valid <= 1'b0;
    end
  end

  // Lookups see the table before this cycle's update
  always_ff @(posedge clock) begin
    if (take) begin
      ren_op       <= buf_op;
      ren_imm      <= buf_imm;
      ren_dest     <= buf_dest;
      ren_tag      <= free_tag;
      ren_old_tag  <= map_table[buf_dest];
      ren_src1_tag <= map_table[buf_src1];
      ren_src2_tag <= map_table[buf_src2];
    end
  end

endmodule

`default_nettype wire

// ==== rename/free_list.sv ====
`timescale 1ns/10ps
`default_nettype none

module free_list (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  alloc,
  input  logic                  reclaim_valid,
  input  rename_pkg::phys_reg_t reclaim_tag,
  output logic                  free_valid,
  output rename_pkg::phys_reg_t free_tag
);

  import rename_pkg::*;

  typedef logic [$clog2(num_free+1)-1:0] fl_count_t;

  phys_reg_t                   tags [num_free];
  logic [$clog2(num_free)-1:0] head;
  logic [$clog2(num_free)-1:0] tail;
  fl_count_t                   count;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      // Tags above the architectural range start out free
      for (int i = 0; i < num_free; i++) begin
        tags[i] <= phys_reg_t'(num_arch_regs + i);
      end
      head  <= '0;
      tail  <= '0;  // Full queue, tail has wrapped onto head
      count <= fl_count_t'(num_free);
    end else begin
      if (reclaim_valid) begin
        tags[tail] <= reclaim_tag;
        tail       <= tail + 1'b1;
      end
      if (alloc) head <= head + 1'b1;
      case ({reclaim_valid, alloc})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  assign free_valid = (count != '0);
  assign free_tag   = tags[head];

endmodule

`default_nettype wire

// ==== source/inst_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module inst_buffer (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  rename_pkg::op_t       in_op,
  input  rename_pkg::arch_reg_t in_dest,
  input  rename_pkg::arch_reg_t in_src1,
  input  rename_pkg::arch_reg_t in_src2,
  input  rename_pkg::imm_t      in_imm,
  input  logic                  buf_ready,
  output logic                  in_ready,
  output logic                  buf_valid,
  output rename_pkg::op_t       buf_op,
  output rename_pkg::arch_reg_t buf_dest,
  output rename_pkg::arch_reg_t buf_src1,
  output rename_pkg::arch_reg_t buf_src2,
  output rename_pkg::imm_t      buf_imm
);

  import rename_pkg::*;

  typedef logic [$clog2(buffer_depth+1)-1:0] cnt_t;

  op_t       op_q   [buffer_depth];
  arch_reg_t dest_q [buffer_depth];
  arch_reg_t src1_q [buffer_depth];
  arch_reg_t src2_q [buffer_depth];
  imm_t      imm_q  [buffer_depth];

  logic [$clog2(buffer_depth)-1:0] head;
  logic [$clog2(buffer_depth)-1:0] tail;
  cnt_t                            count;
  logic                            push;
  logic                            pop;

  assign in_ready = (count != cnt_t'(buffer_depth));
  assign push     = in_valid && in_ready;
  // Refill the output register when it is empty or being taken
  assign pop      = (count != '0) && (!buf_valid || buf_ready);

  always_ff @(posedge clock) begin
    if (push) begin
      op_q[tail]   <= in_op;
      dest_q[tail] <= in_dest;
      src1_q[tail] <= in_src1;
      src2_q[tail] <= in_src2;
      imm_q[tail]  <= in_imm;
    end
    if (pop) begin
      buf_op   <= op_q[head];
      buf_dest <= dest_q[head];
      buf_src1 <= src1_q[head];
      buf_src2 <= src2_q[head];
      buf_imm  <= imm_q[head];
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      buf_valid <= 1'b0;
    end else begin
      if (push) tail <= tail + 1'b1;
      if (pop) head <= head + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
      if (pop) buf_valid <= 1'b1;
      else if (buf_ready) buf_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== common/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

  localparam int num_arch_regs = 32;
  localparam int num_phys_regs = 48;
  localparam int num_free      = num_phys_regs - num_arch_regs;
  localparam int buffer_depth  = 4;

  // Architectural register index
  typedef logic [$clog2(num_arch_regs)-1:0] arch_reg_t;

  // Physical tag
  typedef logic [$clog2(num_phys_regs)-1:0] phys_reg_t;

  typedef logic [31:0] word_t;
  typedef logic [15:0] imm_t;  // Zero-extended on use

  typedef enum logic [1:0] {
    op_li  = 2'd0,
    op_add = 2'd1,
    op_sub = 2'd2,
    op_xor = 2'd3
  } op_t;

endpackage

`default_nettype wire
